//--- fetch_consts.svh
/* sizing for the fetch unit; FIFO depth and outstanding limit may change,
   the trap vector layout assumes a 32-bit address */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

//////////////////////////////
// datapath

// instruction and address width
`define FETCH_XLEN 32

//////////////////////////////
// prefetch sizing

`define FETCH_FIFO_DEPTH 2       // words held in the prefetch FIFO
`define FETCH_MAX_OUTSTANDING 2  // live granted requests awaiting rvalid

//////////////////////////////
// trap vector layout

`define FETCH_VEC_W 6            // interrupt cause field
`define FETCH_TRAP_BASE_W 24     // upper bits of the trap vector base

`endif

//--- fetch_pkg.sv
/* enum types shared by the fetch unit; encodings follow the core controller */
`default_nettype none

package fetch_pkg;

  // next fetch address source, chosen by the controller on pc_set
  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000,  // reset vector
    PC_FENCEI    = 4'b0001,  // refetch after fence.i
    PC_JUMP      = 4'b0010,  // jal/jalr resolved in decode
    PC_BRANCH    = 4'b0011,  // conditional branch resolved in execute
    PC_EXCEPTION = 4'b0100,  // trap handler, see exc_pc_mux_e
    PC_MRET      = 4'b0101,
    PC_URET      = 4'b0110,
    PC_DRET      = 4'b0111
  } pc_mux_e;

  // flavour of trap target
  typedef enum logic [2:0] {
    EXC_PC_EXCEPTION = 3'b000,  // synchronous exception, base only
    EXC_PC_IRQ       = 3'b001,  // vectored by cause
    EXC_PC_DBD       = 3'b010   // debug halt entry
  } exc_pc_mux_e;

  // privilege level whose trap base and cause apply
  typedef enum logic [1:0] {
    TRAP_MACHINE = 2'b00,
    TRAP_USER    = 2'b01
  } trap_mux_e;

  // fetch controller
  typedef enum logic [0:0] {
    FETCH_IDLE = 1'b0,  // out of reset, nothing requested yet
    FETCH_WAIT = 1'b1   // streaming words to decode
  } fetch_state_e;

endpackage

`default_nettype wire

//--- fetch_stream_if.sv
/* a word moves on every cycle with valid and ready high; pc belongs to rdata */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

interface fetch_stream_if;

  logic                   valid;  // word on offer
  logic                   ready;  // consumer takes it this cycle
  logic [`FETCH_XLEN-1:0] rdata;  // instruction word
  logic [`FETCH_XLEN-1:0] pc;     // address it was fetched from

  // producer side, the prefetch buffer
  modport src (output valid, output rdata, output pc, input ready);

  // consumer side, the IF/ID register
  modport dst (input valid, input rdata, input pc, output ready);

endinterface

`default_nettype wire

//--- fetch_top.sv
/* select inputs are sampled only while pc_set_i is high; the bus must
   answer every grant with exactly one in-order rvalid */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module fetch_top (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          req_i,
  // next pc sources
  input  wire logic [`FETCH_XLEN-2:0]        boot_addr_i,
  input  wire logic [`FETCH_XLEN-3:0]        dm_halt_addr_i,
  input  wire logic [`FETCH_TRAP_BASE_W-1:0] m_trap_base_addr_i,
  input  wire logic [`FETCH_TRAP_BASE_W-1:0] u_trap_base_addr_i,
  input  wire logic [1:0]                    trap_addr_mux_i,  // trap_mux_e
  input  wire logic [2:0]                    exc_pc_mux_i,     // exc_pc_mux_e
  input  wire logic [`FETCH_VEC_W-1:0]       m_exc_vec_i,
  input  wire logic [`FETCH_VEC_W-1:0]       u_exc_vec_i,
  input  wire logic [`FETCH_XLEN-1:0]        jump_target_id_i,
  input  wire logic [`FETCH_XLEN-1:0]        jump_target_ex_i,
  input  wire logic [`FETCH_XLEN-1:0]        mepc_i,
  input  wire logic [`FETCH_XLEN-1:0]        uepc_i,
  input  wire logic [`FETCH_XLEN-1:0]        depc_i,
  input  wire logic [3:0]                    pc_mux_i,         // pc_mux_e
  input  wire logic                          pc_set_i,
  // decode side
  input  wire logic                          clear_instr_valid_i,
  input  wire logic                          halt_if_i,
  input  wire logic                          id_ready_i,
  output logic                               instr_valid_id_o,
  output logic [`FETCH_XLEN-1:0]             instr_rdata_id_o,
  output logic [`FETCH_XLEN-1:0]             pc_id_o,
  // instruction bus
  output logic                               instr_req_o,
  output logic [`FETCH_XLEN-1:0]             instr_addr_o,
  input  wire logic                          instr_gnt_i,
  input  wire logic                          instr_rvalid_i,
  input  wire logic [`FETCH_XLEN-1:0]        instr_rdata_i,
  output logic                               if_busy_o
);

  fetch_pkg::pc_mux_e     pc_mux;
  fetch_pkg::exc_pc_mux_e exc_pc_mux;
  fetch_pkg::trap_mux_e   trap_mux;
  logic                   branch;       // redirect strobe to prefetch
  logic [`FETCH_XLEN-1:0] branch_addr;

  // plain selects from the ports become typed selects
  assign pc_mux     = fetch_pkg::pc_mux_e'(pc_mux_i);
  assign exc_pc_mux = fetch_pkg::exc_pc_mux_e'(exc_pc_mux_i);
  assign trap_mux   = fetch_pkg::trap_mux_e'(trap_addr_mux_i);

  fetch_stream_if u_stream ();

  pc_select u_pc_select (
    .boot_addr_i        (boot_addr_i),
    .dm_halt_addr_i     (dm_halt_addr_i),
    .m_trap_base_addr_i (m_trap_base_addr_i),
    .u_trap_base_addr_i (u_trap_base_addr_i),
    .trap_addr_mux_i    (trap_mux),
    .exc_pc_mux_i       (exc_pc_mux),
    .m_exc_vec_i        (m_exc_vec_i),
    .u_exc_vec_i        (u_exc_vec_i),
    .jump_target_id_i   (jump_target_id_i),
    .jump_target_ex_i   (jump_target_ex_i),
    .mepc_i             (mepc_i),
    .uepc_i             (uepc_i),
    .depc_i             (depc_i),
    .pc_mux_i           (pc_mux),
    .pc_id_i            (pc_id_o),      // fence.i restarts after the decode word
    .branch_addr_o      (branch_addr)
  );

  prefetch_buffer u_prefetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .out_if         (u_stream.src),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .busy_o         (if_busy_o)
  );

  if_id_stage u_if_id (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .in_if               (u_stream.dst),
    .branch_o            (branch),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o)
  );

endmodule

`default_nettype wire

//--- if_id_stage.sv
/* pc_set_i hides the word on offer in the same cycle; instruction and pc
   registers hold garbage until the first word loads */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module if_id_stage (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              req_i,                // core wants instructions
  input  wire logic              pc_set_i,             // redirect from controller
  input  wire logic              clear_instr_valid_i,  // decode consumed the word
  input  wire logic              halt_if_i,
  input  wire logic              id_ready_i,
  fetch_stream_if.dst            in_if,
  output logic                   branch_o,             // load new pc into prefetch
  output logic                   instr_valid_id_o,
  output logic [`FETCH_XLEN-1:0] instr_rdata_id_o,
  output logic [`FETCH_XLEN-1:0] pc_id_o
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;
  logic                    offer;     // word presented to decode
  logic                    if_valid;  // word moves into the IF/ID register

  //////////////////////////////
  // fetch controller

  always_comb begin
    state_d  = state_q;
    offer    = 1'b0;
    branch_o = 1'b0;
    unique case (state_q)
      fetch_pkg::FETCH_IDLE: begin
        if (req_i) begin
          branch_o = 1'b1;  // start at the boot address
          state_d  = fetch_pkg::FETCH_WAIT;
        end
      end
      fetch_pkg::FETCH_WAIT: begin
        offer = in_if.valid & req_i;
      end
      default: state_d = fetch_pkg::FETCH_IDLE;
    endcase

    // redirect wins over everything, the current word is stale
    if (pc_set_i) begin
      offer    = 1'b0;
      branch_o = 1'b1;
      state_d  = fetch_pkg::FETCH_WAIT;
    end
  end

  assign if_valid    = offer & id_ready_i & ~halt_if_i;
  assign in_if.ready = if_valid;  // stalled decode back-pressures the FIFO

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q          <= fetch_pkg::FETCH_IDLE;
      instr_valid_id_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (if_valid) begin
        instr_valid_id_o <= 1'b1;
      end else if (clear_instr_valid_i) begin
        instr_valid_id_o <= 1'b0;
      end
    end
  end

  // IF/ID payload, frozen while decode stalls
  always_ff @(posedge clk) begin
    if (if_valid) begin
      instr_rdata_id_o <= in_if.rdata;
      pc_id_o          <= in_if.pc;
    end
  end

endmodule

`default_nettype wire

//--- pc_select.sv
/* combinational only; the vectored IRQ target is 33 bits wide and loses the
   top trap base bit, bit 0 of the result is always zero */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module pc_select (
  input  wire logic [`FETCH_XLEN-2:0]        boot_addr_i,       // halfword aligned
  input  wire logic [`FETCH_XLEN-3:0]        dm_halt_addr_i,    // word aligned
  input  wire logic [`FETCH_TRAP_BASE_W-1:0] m_trap_base_addr_i,
  input  wire logic [`FETCH_TRAP_BASE_W-1:0] u_trap_base_addr_i,
  input  wire fetch_pkg::trap_mux_e          trap_addr_mux_i,
  input  wire fetch_pkg::exc_pc_mux_e        exc_pc_mux_i,
  input  wire logic [`FETCH_VEC_W-1:0]       m_exc_vec_i,       // machine irq cause
  input  wire logic [`FETCH_VEC_W-1:0]       u_exc_vec_i,       // user irq cause
  input  wire logic [`FETCH_XLEN-1:0]        jump_target_id_i,
  input  wire logic [`FETCH_XLEN-1:0]        jump_target_ex_i,
  input  wire logic [`FETCH_XLEN-1:0]        mepc_i,
  input  wire logic [`FETCH_XLEN-1:0]        uepc_i,
  input  wire logic [`FETCH_XLEN-1:0]        depc_i,
  input  wire fetch_pkg::pc_mux_e            pc_mux_i,
  input  wire logic [`FETCH_XLEN-1:0]        pc_id_i,           // pc of the word in decode
  output logic [`FETCH_XLEN-1:0]             branch_addr_o
);

  logic [`FETCH_TRAP_BASE_W-1:0] trap_base;   // base of the active privilege
  logic [`FETCH_VEC_W-1:0]       exc_vec;     // cause of the active privilege
  logic [`FETCH_XLEN:0]          irq_full;    // one bit wider than an address
  logic [`FETCH_XLEN-1:0]        exc_pc;      // trap or debug entry point
  logic [`FETCH_XLEN-1:0]        fetch_addr;

  //////////////////////////////
  // trap target

  always_comb begin
    unique case (trap_addr_mux_i)
      fetch_pkg::TRAP_USER: begin
        trap_base = u_trap_base_addr_i;
        exc_vec   = u_exc_vec_i;
      end
      default: begin  // machine mode
        trap_base = m_trap_base_addr_i;
        exc_vec   = m_exc_vec_i;
      end
    endcase
  end

  // base, zero bit, cause, word offset
  assign irq_full = {trap_base, 1'b0, exc_vec, 2'b00};

  always_comb begin
    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_IRQ: exc_pc = irq_full[`FETCH_XLEN-1:0];  // msb falls off
      fetch_pkg::EXC_PC_DBD: exc_pc = {dm_halt_addr_i, 2'b00};
      default:               exc_pc = {trap_base, 8'h00};  // all exceptions share base
    endcase
  end

  //////////////////////////////
  // next fetch address

  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_JUMP:      fetch_addr = jump_target_id_i;
      fetch_pkg::PC_BRANCH:    fetch_addr = jump_target_ex_i;
      fetch_pkg::PC_EXCEPTION: fetch_addr = exc_pc;
      fetch_pkg::PC_MRET:      fetch_addr = mepc_i;   // return from machine trap
      fetch_pkg::PC_URET:      fetch_addr = uepc_i;   // return from user trap
      fetch_pkg::PC_DRET:      fetch_addr = depc_i;   // leave debug mode
      fetch_pkg::PC_FENCEI:    fetch_addr = pc_id_i + `FETCH_XLEN'(4);  // refetch next word
      default:                 fetch_addr = {boot_addr_i, 1'b0};
    endcase
  end

  assign branch_addr_o = {fetch_addr[`FETCH_XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

//--- prefetch_buffer.sv
/* needs an in-order bus with exactly one rvalid per grant; the FIFO is not
   fall-through, so a word reaches out_if one cycle after its rvalid */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module prefetch_buffer (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   branch_i,        // redirect strobe
  input  wire logic [`FETCH_XLEN-1:0] branch_addr_i,
  fetch_stream_if.src                 out_if,
  output logic                        instr_req_o,
  output logic [`FETCH_XLEN-1:0]      instr_addr_o,
  input  wire logic                   instr_gnt_i,
  input  wire logic                   instr_rvalid_i,
  input  wire logic [`FETCH_XLEN-1:0] instr_rdata_i,
  output logic                        busy_o
);

  localparam int DEPTH   = `FETCH_FIFO_DEPTH;
  localparam int OUT_CAP = 2 * `FETCH_MAX_OUTSTANDING;  // live plus stale
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int FCNT_W  = $clog2(DEPTH + 1);
  localparam int OCNT_W  = $clog2(OUT_CAP + 1);
  localparam int SUM_W   = FCNT_W + OCNT_W;

  // request side
  logic                   active_q;     // set by the first branch after reset
  logic [`FETCH_XLEN-1:0] addr_q;       // next address to request
  logic                   gnt_acc;      // request taken by the bus
  logic [SUM_W-1:0]       credit_used;  // FIFO slots spoken for

  // response tracking
  logic [OCNT_W-1:0]      out_q;        // granted, rvalid still due
  logic [OCNT_W-1:0]      out_d;
  logic [OCNT_W-1:0]      disc_q;       // of those, still to be dropped
  logic [OCNT_W-1:0]      live_cnt;     // responses that will be kept
  logic [`FETCH_XLEN-1:0] resp_pc_q;    // pc of the next kept response
  logic                   push;
  logic                   pop;

  // FIFO storage
  logic [`FETCH_XLEN-1:0] mem_data [DEPTH];
  logic [`FETCH_XLEN-1:0] mem_pc   [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [FCNT_W-1:0]      fcnt_q;

  // wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + PTR_W'(1);
  endfunction

  //////////////////////////////
  // request generation

  assign live_cnt    = out_q - disc_q;
  assign credit_used = SUM_W'(fcnt_q) + SUM_W'(live_cnt);

  // only words already owed a FIFO slot may be in flight
  assign instr_req_o = active_q
                     && (live_cnt < OCNT_W'(`FETCH_MAX_OUTSTANDING))
                     && (credit_used < SUM_W'(DEPTH))
                     && (out_q < OCNT_W'(OUT_CAP));
  assign instr_addr_o = addr_q;
  assign gnt_acc      = instr_req_o & instr_gnt_i;

  assign out_d = out_q + OCNT_W'(gnt_acc) - OCNT_W'(instr_rvalid_i);

  // stale words never enter the FIFO, nor does anything during a redirect
  assign push = instr_rvalid_i && (disc_q == '0) && !branch_i;
  assign pop  = out_if.valid && out_if.ready;

  assign busy_o = (out_q != '0) || instr_req_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      addr_q    <= '0;
      resp_pc_q <= '0;
      out_q     <= '0;
      disc_q    <= '0;
    end else begin
      out_q <= out_d;
      if (branch_i) begin
        active_q  <= 1'b1;
        addr_q    <= branch_addr_i;  // replaces any ungranted request
        resp_pc_q <= branch_addr_i;
        disc_q    <= out_d;          // a grant in this cycle is stale too
      end else begin
        if (gnt_acc) begin
          addr_q <= addr_q + `FETCH_XLEN'(4);
        end
        if (push) begin
          resp_pc_q <= resp_pc_q + `FETCH_XLEN'(4);
        end
        if (instr_rvalid_i && (disc_q != '0)) begin
          disc_q <= disc_q - OCNT_W'(1);  // one stale word gone
        end
      end
    end
  end

  //////////////////////////////
  // FIFO

  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr_q] <= instr_rdata_i;
      mem_pc[wr_ptr_q]   <= resp_pc_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fcnt_q   <= '0;
    end else if (branch_i) begin  // flush
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fcnt_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      fcnt_q <= fcnt_q + FCNT_W'(push) - FCNT_W'(pop);
    end
  end

  assign out_if.valid = (fcnt_q != '0);
  assign out_if.rdata = mem_data[rd_ptr_q];
  assign out_if.pc    = mem_pc[rd_ptr_q];

endmodule

`default_nettype wire

//--- project.f
+incdir+.
fetch_pkg.sv
fetch_stream_if.sv
pc_select.sv
prefetch_buffer.sv
if_id_stage.sv
fetch_top.sv
tb_instr_mem.sv
tb_fetch_top.sv

//--- tb_fetch_top.sv
/* table driven redirect test of the fetch unit; row targets must keep bit 1
   clear, and a fence.i row must follow a row that consumed words */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module tb_fetch_top;

  localparam logic [31:0] MEM_KEY   = 32'h5a5a_0000;   // memory returns addr ^ key
  localparam logic [30:0] BOOT_ADDR = 31'h0000_0040;   // boot pc 0x80
  localparam int          NROWS     = 14;
  localparam int          WORDS     = 4;               // most words consumed per row
  localparam int          LIMIT     = 4 + (NROWS + 3) * 64 * WORDS;

  typedef struct packed {
    logic [3:0]              pc_mux;
    logic [2:0]              exc_mux;
    logic [1:0]              trap;
    logic [`FETCH_VEC_W-1:0] vec;
    logic [31:0]             operand;  // jump_id; other sources get fixed offsets
    logic [3:0]              count;    // words to consume after the redirect
    logic [3:0]              rdy_pat;  // id_ready per cycle, repeats every 4
    logic [3:0]              hlt_pat;  // halt_if per cycle
    logic                    rel;      // target is the next pc of the old stream
    logic [31:0]             target;
  } row_t;

  row_t rows [NROWS];

  logic clk;
  logic rst_n;
  logic req_i, pc_set_i, clear_instr_valid_i, halt_if_i, id_ready_i;
  logic [30:0] boot_addr_i;
  logic [29:0] dm_halt_addr_i;
  logic [`FETCH_TRAP_BASE_W-1:0] m_trap_base_addr_i, u_trap_base_addr_i;
  logic [1:0] trap_addr_mux_i;
  logic [2:0] exc_pc_mux_i;
  logic [3:0] pc_mux_i;
  logic [`FETCH_VEC_W-1:0] m_exc_vec_i, u_exc_vec_i;
  logic [31:0] jump_target_id_i, jump_target_ex_i, mepc_i, uepc_i, depc_i;
  logic instr_valid_id_o, instr_req_o, instr_gnt_i, instr_rvalid_i, if_busy_o;
  logic [31:0] instr_rdata_id_o, pc_id_o, instr_addr_o, instr_rdata_i;

  // consumer model state
  logic        req_on = 1'b0;
  logic [31:0] exp_pc;
  logic        prev_rdy = 1'b0, prev_hlt = 1'b0, prev_clr = 1'b0;
  logic        last_valid = 1'b0;
  logic        addr_due = 1'b0;  // bus must show exp_pc in this cycle
  logic [31:0] last_pc, last_rdata;
  int          word_count = 0, check_count = 0, error_count = 0, cycle_count = 0;

  fetch_top u_dut (
    .clk (clk), .rst_n (rst_n), .req_i (req_i),
    .boot_addr_i (boot_addr_i), .dm_halt_addr_i (dm_halt_addr_i),
    .m_trap_base_addr_i (m_trap_base_addr_i), .u_trap_base_addr_i (u_trap_base_addr_i),
    .trap_addr_mux_i (trap_addr_mux_i), .exc_pc_mux_i (exc_pc_mux_i),
    .m_exc_vec_i (m_exc_vec_i), .u_exc_vec_i (u_exc_vec_i),
    .jump_target_id_i (jump_target_id_i), .jump_target_ex_i (jump_target_ex_i),
    .mepc_i (mepc_i), .uepc_i (uepc_i), .depc_i (depc_i),
    .pc_mux_i (pc_mux_i), .pc_set_i (pc_set_i),
    .clear_instr_valid_i (clear_instr_valid_i), .halt_if_i (halt_if_i),
    .id_ready_i (id_ready_i), .instr_valid_id_o (instr_valid_id_o),
    .instr_rdata_id_o (instr_rdata_id_o), .pc_id_o (pc_id_o),
    .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i), .if_busy_o (if_busy_o)
  );

  tb_instr_mem u_mem (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req_o), .addr_i (instr_addr_o),
    .gnt_o (instr_gnt_i), .rvalid_o (instr_rvalid_i), .rdata_o (instr_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", LIMIT);
      $display("checks %0d, words %0d, errors %0d", check_count, word_count, error_count);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////
  // one cycle of the decode side

  task automatic run_cycle(input logic rdy, input logic hlt, input logic clr,
                           input logic set, input int r);
    @(posedge clk);
    req_i               <= req_on;
    id_ready_i          <= rdy;
    halt_if_i           <= hlt;
    clear_instr_valid_i <= clr;
    pc_set_i            <= set;
    if (set) begin  // select inputs only matter while pc_set is high
      pc_mux_i         <= rows[r].pc_mux;
      exc_pc_mux_i     <= rows[r].exc_mux;
      trap_addr_mux_i  <= rows[r].trap;
      m_exc_vec_i      <= (rows[r].trap == fetch_pkg::TRAP_USER) ? ~rows[r].vec : rows[r].vec;
      u_exc_vec_i      <= (rows[r].trap == fetch_pkg::TRAP_USER) ? rows[r].vec : ~rows[r].vec;
      jump_target_id_i <= rows[r].operand;
      jump_target_ex_i <= rows[r].operand + 32'h100;
      mepc_i           <= rows[r].operand + 32'h200;
      uepc_i           <= rows[r].operand + 32'h300;
      depc_i           <= rows[r].operand + 32'h400;
    end
    @(negedge clk);
    if (addr_due) begin  // new fetch address requested one cycle after the redirect
      check_value("instr_req_o", instr_req_o, 1'b1);
      check_value("instr_addr_o", instr_addr_o, exp_pc);
      check_value("if_busy_o", if_busy_o, 1'b1);
    end
    // outputs now show what the previous cycle's inputs allowed
    if (prev_rdy && !prev_hlt) begin
      if (instr_valid_id_o) begin  // fresh word, since clear was high
        check_value("pc_id_o", pc_id_o, exp_pc);
        check_value("instr_rdata_id_o", instr_rdata_id_o, exp_pc ^ MEM_KEY);
        exp_pc = exp_pc + 32'd4;
        word_count++;
      end
    end else begin  // stalled, register holds
      check_value("instr_valid_id_o", instr_valid_id_o, prev_clr ? 1'b0 : last_valid);
      check_value("pc_id_o", pc_id_o, last_pc);
      check_value("instr_rdata_id_o", instr_rdata_id_o, last_rdata);
    end
    last_valid = instr_valid_id_o;
    last_pc    = pc_id_o;
    last_rdata = instr_rdata_id_o;
    prev_rdy   = rdy;
    prev_hlt   = hlt;
    prev_clr   = clr;
    if (set && !rows[r].rel) begin
      exp_pc = rows[r].target;  // fence.i keeps exp_pc, which is pc_id + 4
    end
    addr_due = set;
  endtask

  initial begin
    int   start;
    int   k;
    logic rdy;
    logic hlt;

    // targets from the pc_select rules, m base 0x10, u base 0x30, halt 0x200
    rows[0]  = '{fetch_pkg::PC_JUMP, 3'd0, 2'd0, 6'd0, 32'h0000_4000,
                 4'd4, 4'b1111, 4'b0000, 1'b0, 32'h0000_4000};
    rows[1]  = '{fetch_pkg::PC_BRANCH, 3'd0, 2'd0, 6'd0, 32'h0000_5000,
                 4'd4, 4'b0101, 4'b0000, 1'b0, 32'h0000_5100};
    rows[2]  = '{fetch_pkg::PC_MRET, 3'd0, 2'd0, 6'd0, 32'h0000_6000,
                 4'd3, 4'b1111, 4'b0100, 1'b0, 32'h0000_6200};
    rows[3]  = '{fetch_pkg::PC_URET, 3'd0, 2'd0, 6'd0, 32'h0000_7000,
                 4'd4, 4'b0001, 4'b0000, 1'b0, 32'h0000_7300};   // long stall
    rows[4]  = '{fetch_pkg::PC_DRET, 3'd0, 2'd0, 6'd0, 32'h0000_8000,
                 4'd3, 4'b1011, 4'b0001, 1'b0, 32'h0000_8400};
    rows[5]  = '{fetch_pkg::PC_FENCEI, 3'd0, 2'd0, 6'd0, 32'h0000_f000,
                 4'd4, 4'b1111, 4'b0000, 1'b1, 32'h0};
    rows[6]  = '{fetch_pkg::PC_JUMP, 3'd0, 2'd0, 6'd0, 32'h0000_9001,
                 4'd3, 4'b1111, 4'b0000, 1'b0, 32'h0000_9000};   // bit 0 dropped
    rows[7]  = '{fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_EXCEPTION, fetch_pkg::TRAP_MACHINE,
                 6'd5, 32'h0000_f000, 4'd3, 4'b1111, 4'b0000, 1'b0, 32'h0000_1000};
    rows[8]  = '{fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_EXCEPTION, fetch_pkg::TRAP_USER,
                 6'd5, 32'h0000_f000, 4'd3, 4'b0110, 4'b0000, 1'b0, 32'h0000_3000};
    rows[9]  = '{fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_IRQ, fetch_pkg::TRAP_MACHINE,
                 6'd0, 32'h0000_f000, 4'd3, 4'b1111, 4'b0000, 1'b0, 32'h0000_2000};
    rows[10] = '{fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_IRQ, fetch_pkg::TRAP_MACHINE,
                 6'd17, 32'h0000_f000, 4'd3, 4'b1111, 4'b1000, 1'b0, 32'h0000_2044};
    rows[11] = '{fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_IRQ, fetch_pkg::TRAP_MACHINE,
                 6'd63, 32'h0000_f000, 4'd3, 4'b1111, 4'b0000, 1'b0, 32'h0000_20fc};
    rows[12] = '{fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_IRQ, fetch_pkg::TRAP_USER,
                 6'd17, 32'h0000_f000, 4'd3, 4'b0011, 4'b0000, 1'b0, 32'h0000_6044};
    rows[13] = '{fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_DBD, fetch_pkg::TRAP_MACHINE,
                 6'd0, 32'h0000_f000, 4'd4, 4'b1111, 4'b0000, 1'b0, 32'h0000_0800};

    rst_n = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    clear_instr_valid_i = 1'b0;
    halt_if_i = 1'b0;
    id_ready_i = 1'b0;
    boot_addr_i = BOOT_ADDR;
    dm_halt_addr_i = 30'h0000_0200;
    m_trap_base_addr_i = 24'h00_0010;
    u_trap_base_addr_i = 24'h00_0030;
    trap_addr_mux_i = fetch_pkg::TRAP_MACHINE;
    exc_pc_mux_i = fetch_pkg::EXC_PC_EXCEPTION;
    pc_mux_i = fetch_pkg::PC_BOOT;  // first request fetches from boot
    m_exc_vec_i = '0;
    u_exc_vec_i = '0;
    jump_target_id_i = '0;
    jump_target_ex_i = '0;
    mepc_i = '0;
    uepc_i = '0;
    depc_i = '0;
    exp_pc = {BOOT_ADDR, 1'b0};
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // quiet until req rises
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, -1);
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, -1);
    check_value("instr_req_o", instr_req_o, 1'b0);
    check_value("instr_valid_id_o", instr_valid_id_o, 1'b0);
    check_value("if_busy_o", if_busy_o, 1'b0);

    ////////////////////////////////
    // boot stream, then clear while stalled

    req_on = 1'b1;
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, -1);  // first req, fetch starts at boot
    addr_due = 1'b1;
    while (word_count < 6) run_cycle(1'b1, 1'b0, 1'b1, 1'b0, -1);
    repeat (8) run_cycle(1'b0, 1'b0, 1'b0, 1'b0, -1);  // FIFO fills behind the stall
    run_cycle(1'b1, 1'b0, 1'b1, 1'b0, -1);  // one word into decode
    run_cycle(1'b0, 1'b0, 0, 1'b0, -1);
    check_value("instr_valid_id_o", instr_valid_id_o, 1'b1);
    run_cycle(1'b0, 1'b0, 1'b1, 1'b0, -1);  // clear with decode stalled
    run_cycle(1'b0, 1'b0, 1'b0, 1'b0, -1);  // valid must be low here
    start = word_count;
    while (word_count - start < 2) run_cycle(1'b1, 1'b0, 1'b1, 1'b0, -1);

    ////////////////////////////////
    // redirect table

    for (int r = 0; r < NROWS; r++) begin
      run_cycle(1'b1, 1'b0, 1'b1, 1'b1, r);
      start = word_count;
      k = 0;
      while (word_count - start < int'(rows[r].count)) begin
        rdy = rows[r].rdy_pat[k % 4];
        hlt = rows[r].hlt_pat[k % 4];
        run_cycle(rdy, hlt, rdy & ~hlt, 1'b0, r);
        k++;
      end
    end

    $display("checks %0d, words %0d, errors %0d", check_count, word_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_instr_mem.sv
/* grants after 0 to 3 cycles and answers one cycle after each grant, in order;
   no error response, rdata is the address XOR a fixed key */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_consts.svh"

module tb_instr_mem (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   req_i,
  input  wire logic [`FETCH_XLEN-1:0] addr_i,
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic [`FETCH_XLEN-1:0]      rdata_o
);

  localparam logic [`FETCH_XLEN-1:0] MEM_KEY = 32'h5a5a_0000;

  logic [31:0] seed_q;     // LCG state
  logic [31:0] seed_next;
  logic [1:0]  delay_q;    // wait cycles left before the next grant

  // numerical recipes multiplier and increment
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  assign seed_next = lcg_next(seed_q);
  assign gnt_o     = req_i && (delay_q == 2'd0);  // grant in the same cycle as req

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seed_q   <= 32'h7a18;
      delay_q  <= 2'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= gnt_o;  // exactly one response per grant
      if (gnt_o) begin
        rdata_o <= addr_i ^ MEM_KEY;
        seed_q  <= seed_next;
        delay_q <= seed_next[17:16];  // upper bits are the better random ones
      end else if (req_i && (delay_q != 2'd0)) begin
        delay_q <= delay_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire
